//--- src/layer_reader_cfg.svh
// -----------------------------------------------
// layer reader configuration
// memory layout, widths and apb register map
// -----------------------------------------------
`ifndef LAYER_READER_CFG_SVH
`define LAYER_READER_CFG_SVH

// one image row is a single 8 beat burst
`define LR_ROW_BYTES 64
// each layer sits in its own 4k block
`define LR_LAYER_BYTES 4096
`define LR_BEAT_BYTES 8
`define LR_BURST_BEATS 8

// address width and width of every count or id
`define LR_ADDR_W 32
`define LR_DIM_W 10

// apb register offsets
`define LR_REG_CTRL 'h00
`define LR_REG_BASE 'h04
`define LR_REG_LAYERS 'h08
`define LR_REG_ROWS 'h0C
`define LR_REG_COLS 'h10
`define LR_REG_STATUS 'h14

`endif

//--- src/layer_reader_pkg.sv
// -----------------------------------------------
// layer reader shared types
// run configuration, read beats and 3x3 windows
// -----------------------------------------------
`default_nettype none

`include "layer_reader_cfg.svh"

package layer_reader_pkg;

	// count or id of a layer, row or column
	typedef logic [`LR_DIM_W-1:0] dim_t;

	// configuration frozen at start
	typedef struct packed {
		logic [`LR_ADDR_W-1:0] base;
		dim_t layer_count;
		dim_t row_count;
		dim_t col_count;
	} cfg_t;

	// one axi read data beat
	typedef struct packed {
		logic [`LR_BEAT_BYTES*8-1:0] data;
		logic last;
	} rd_beat_t;

	// three neighbouring bytes of one row
	// element 2 holds the earliest column
	typedef logic [2:0][7:0] win_row_t;

	// 3x3 window with its ids
	// pix[0] is row r-1, pix[2] is row r+1
	typedef struct packed {
		win_row_t [0:2] pix;
		dim_t layer;
		dim_t row;
		dim_t col;
	} window_t;

endpackage

`default_nettype wire

//--- src/elastic_buffer.sv
// -----------------------------------------------
// elastic buffer
// two entry skid buffer on a valid/ready link
// -----------------------------------------------
`default_nettype none

module elastic_buffer #(
	parameter type payload_t = logic
) (
	input  logic clk,
	input  logic reset_n,
	input  logic in_valid,
	output logic in_ready,
	input  payload_t in_data,
	output logic out_valid,
	input  logic out_ready,
	output payload_t out_data
);
	payload_t skid_data;
	logic skid_valid;
	logic skid_valid_n;
	logic out_valid_n;
	logic load_out;
	logic in_hs;

	assign in_hs = in_valid & in_ready;
	// output register free or draining this cycle
	assign load_out = !out_valid || out_ready;

	always_comb begin
		out_valid_n = out_valid;
		skid_valid_n = skid_valid;
		if (load_out) begin
			out_valid_n = skid_valid || in_hs;
			skid_valid_n = skid_valid && in_hs;
		end else if (in_hs) begin
			skid_valid_n = 1'b1;
		end
	end

	// in_ready registered, low only with both entries full
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			out_valid <= 1'b0;
			skid_valid <= 1'b0;
			in_ready <= 1'b0;
		end else begin
			out_valid <= out_valid_n;
			skid_valid <= skid_valid_n;
			in_ready <= !skid_valid_n;
		end
	end

	always_ff @(posedge clk) begin
		if (load_out) begin
			if (skid_valid)
				out_data <= skid_data;
			else if (in_hs)
				out_data <= in_data;
		end
		if (in_hs && (!load_out || skid_valid))
			skid_data <= in_data;
	end

endmodule

`default_nettype wire

//--- src/apb_cfg_regs.sv
// -----------------------------------------------
// apb configuration registers
// holds base, layer, row and column counts
// start pulse, busy and done status
// -----------------------------------------------
`default_nettype none

`include "layer_reader_cfg.svh"

module apb_cfg_regs (
	input  logic clk,
	input  logic reset_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [`LR_ADDR_W-1:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output layer_reader_pkg::cfg_t cfg,
	output logic start,
	input  logic run_done
);
	import layer_reader_pkg::*;

	logic [`LR_ADDR_W-1:0] base_q;
	dim_t layers_q;
	dim_t rows_q;
	dim_t cols_q;
	logic busy_q;
	logic done_q;
	logic access;
	logic wr_access;
	logic mapped;
	logic start_req;

	// access phase of the two phase transfer
	assign access = psel & penable;
	assign wr_access = access & pwrite;
	// ctrl bit0 starts a run, ignored while busy
	assign start_req = wr_access && (paddr == `LR_REG_CTRL) && pwdata[0] && !busy_q;

	assign pready = 1'b1;
	assign pslverr = access & ~mapped;

	// read mux and address decode
	always_comb begin
		prdata = '0;
		mapped = 1'b1;
		case (paddr)
			`LR_REG_CTRL: prdata = '0;
			`LR_REG_BASE: prdata = base_q;
			`LR_REG_LAYERS: prdata = 32'(layers_q);
			`LR_REG_ROWS: prdata = 32'(rows_q);
			`LR_REG_COLS: prdata = 32'(cols_q);
			`LR_REG_STATUS: prdata = {30'b0, done_q, busy_q};
			default: mapped = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			base_q <= '0;
			layers_q <= '0;
			rows_q <= '0;
			cols_q <= '0;
		end else if (wr_access) begin
			case (paddr)
				`LR_REG_BASE: base_q <= pwdata;
				`LR_REG_LAYERS: layers_q <= pwdata[`LR_DIM_W-1:0];
				`LR_REG_ROWS: rows_q <= pwdata[`LR_DIM_W-1:0];
				`LR_REG_COLS: cols_q <= pwdata[`LR_DIM_W-1:0];
				default: ;
			endcase
		end
	end

	// ------------------------------------------------
	// run control
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			start <= 1'b0;
			busy_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			start <= start_req;
			if (start_req) begin
				busy_q <= 1'b1;
				done_q <= 1'b0;
			end else if (busy_q && run_done && !start) begin
				// run_done of the last run may still be high during start
				busy_q <= 1'b0;
				done_q <= 1'b1;
			end
		end
	end

	// snapshot taken together with the start request
	always_ff @(posedge clk) begin
		if (start_req)
			cfg <= '{base: base_q, layer_count: layers_q, row_count: rows_q, col_count: cols_q};
	end

endmodule

`default_nettype wire

//--- src/row_fetcher.sv
// -----------------------------------------------
// row fetcher
// issues up to three row bursts per group
// (row outer, layer inner) and fills the two
// line buffer banks in turn
// -----------------------------------------------
`default_nettype none

`include "layer_reader_cfg.svh"

module row_fetcher (
	input  logic clk,
	input  logic reset_n,
	input  layer_reader_pkg::cfg_t cfg,
	input  logic start,
	output logic arvalid,
	input  logic arready,
	output logic [`LR_ADDR_W-1:0] araddr,
	input  logic beat_valid,
	output logic beat_ready,
	input  layer_reader_pkg::rd_beat_t beat,
	output logic wr_en,
	output logic wr_bank,
	output logic [1:0] wr_row,
	output logic [$clog2(`LR_BURST_BEATS)-1:0] wr_beat,
	output logic [`LR_BEAT_BYTES*8-1:0] wr_data,
	output logic [1:0] bank_full,
	input  logic bank_release
);
	import layer_reader_pkg::*;

	localparam int ADDR_W = `LR_ADDR_W;

	typedef enum logic [2:0] {F_IDLE, F_WAIT, F_ROW, F_ADDR, F_DATA} state_t;

	state_t state;
	dim_t grp_row;
	dim_t grp_layer;
	dim_t row_idx;
	logic [1:0] row_sel;
	logic fill_bank;
	logic rel_bank;
	logic [$clog2(`LR_BURST_BEATS)-1:0] beat_cnt;
	logic in_range;
	logic beat_hs;
	logic row_end;
	logic grp_end;
	logic last_grp;
	logic [ADDR_W-1:0] row_addr;

	// row r-1+row_sel of the group
	// at row 0 the first slot wraps to all ones, so it falls out of range
	assign row_idx = grp_row + dim_t'(row_sel) - dim_t'(1);
	assign in_range = row_idx < cfg.row_count;
	assign row_addr = cfg.base + ADDR_W'(grp_layer) * `LR_LAYER_BYTES
		+ ADDR_W'(row_idx) * `LR_ROW_BYTES;

	assign beat_ready = (state == F_DATA);
	assign beat_hs = beat_valid & beat_ready;

	// beat write port
	assign wr_en = beat_hs;
	assign wr_bank = fill_bank;
	assign wr_row = row_sel;
	assign wr_beat = beat_cnt;
	assign wr_data = beat.data;

	// a row ends when skipped or on its last beat
	assign row_end = ((state == F_ROW) && !in_range) || (beat_hs && beat.last);
	assign grp_end = row_end && (row_sel == 2'd2);
	assign last_grp = (grp_layer == cfg.layer_count - dim_t'(1))
		&& (grp_row == cfg.row_count - dim_t'(1));

	// ------------------------------------------------
	// burst FSM
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= F_IDLE;
			arvalid <= 1'b0;
			row_sel <= '0;
			fill_bank <= 1'b0;
			grp_row <= '0;
			grp_layer <= '0;
			beat_cnt <= '0;
		end else if (start) begin
			state <= F_WAIT;
			fill_bank <= 1'b0;
			grp_row <= '0;
			grp_layer <= '0;
		end else begin
			case (state)
				// hold off until the streamer has freed this bank
				F_WAIT: if (!bank_full[fill_bank]) begin
					row_sel <= '0;
					state <= F_ROW;
				end
				F_ROW: if (in_range) begin
					arvalid <= 1'b1;
					state <= F_ADDR;
				end
				F_ADDR: if (arready) begin
					arvalid <= 1'b0;
					beat_cnt <= '0;
					state <= F_DATA;
				end
				F_DATA: if (beat_hs) beat_cnt <= beat_cnt + 1'b1;
				default: ;
			endcase

			if (grp_end) begin
				fill_bank <= ~fill_bank;
				if (last_grp) begin
					state <= F_IDLE;
				end else begin
					state <= F_WAIT;
					// layer is the inner loop
					if (grp_layer == cfg.layer_count - dim_t'(1)) begin
						grp_layer <= '0;
						grp_row <= grp_row + dim_t'(1);
					end else begin
						grp_layer <= grp_layer + dim_t'(1);
					end
				end
			end else if (row_end) begin
				row_sel <= row_sel + 2'd1;
				state <= F_ROW;
			end
		end
	end

	// address held with arvalid until arready
	always_ff @(posedge clk) begin
		if ((state == F_ROW) && in_range)
			araddr <= row_addr;
	end

	// ------------------------------------------------
	// bank ownership
	// ------------------------------------------------
	// releases come in the same bank order as the fills
	always_ff @(posedge clk) begin
		if (!reset_n || start) begin
			bank_full <= '0;
			rel_bank <= 1'b0;
		end else begin
			if (bank_release) begin
				bank_full[rel_bank] <= 1'b0;
				rel_bank <= ~rel_bank;
			end
			if (grp_end)
				bank_full[fill_bank] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- src/line_buffer.sv
// -----------------------------------------------
// line buffer
// two banks of three 64 byte rows, written one
// beat at a time, read as a 3x3 byte window
// -----------------------------------------------
`default_nettype none

`include "layer_reader_cfg.svh"

module line_buffer (
	input  logic clk,
	input  logic wr_en,
	input  logic wr_bank,
	input  logic [1:0] wr_row,
	input  logic [$clog2(`LR_BURST_BEATS)-1:0] wr_beat,
	input  logic [`LR_BEAT_BYTES*8-1:0] wr_data,
	input  logic rd_bank,
	input  layer_reader_pkg::dim_t rd_col,
	output layer_reader_pkg::win_row_t [0:2] rd_pix
);
	localparam int BEAT_W = `LR_BEAT_BYTES * 8;
	localparam int ROW_W = `LR_ROW_BYTES * 8;
	localparam int COL_W = $clog2(`LR_ROW_BYTES);

	// byte n of a row sits at bits 8n+7:8n, as on the bus
	logic [ROW_W-1:0] row_q [0:1][0:2];

	always_ff @(posedge clk) begin
		if (wr_en)
			row_q[wr_bank][wr_row][wr_beat*BEAT_W +: BEAT_W] <= wr_data;
	end

	// bytes rd_col..rd_col+2 of each row
	// bytes past the row end read as zero
	always_comb begin
		logic [`LR_DIM_W-1:0] col;
		col = '0;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				col = rd_col + `LR_DIM_W'(j);
				if (col < `LR_ROW_BYTES)
					rd_pix[i][2-j] = row_q[rd_bank][i][col[COL_W-1:0]*8 +: 8];
				else
					rd_pix[i][2-j] = '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/window_streamer.sv
// -----------------------------------------------
// window streamer
// walks row, layer and column over the filled
// banks, pads the image edges with zeros and
// emits one tagged 3x3 window per handshake
// -----------------------------------------------
`default_nettype none

module window_streamer (
	input  logic clk,
	input  logic reset_n,
	input  layer_reader_pkg::cfg_t cfg,
	input  logic start,
	input  logic [1:0] bank_full,
	output logic bank_release,
	output logic rd_bank,
	output layer_reader_pkg::dim_t rd_col,
	input  layer_reader_pkg::win_row_t [0:2] rd_pix,
	output logic out_valid,
	input  logic out_ready,
	output layer_reader_pkg::window_t out_win,
	output logic run_done
);
	import layer_reader_pkg::*;

	logic active;
	dim_t col_q;
	dim_t layer_q;
	dim_t row_q;
	logic out_hs;
	logic last_col;
	logic last_layer;
	logic last_row;
	logic pad_top;
	logic pad_bottom;

	assign rd_col = col_q;
	assign out_valid = active & bank_full[rd_bank];
	assign out_hs = out_valid & out_ready;

	assign last_col = (col_q == cfg.col_count - dim_t'(1));
	assign last_layer = (layer_q == cfg.layer_count - dim_t'(1));
	assign last_row = (row_q == cfg.row_count - dim_t'(1));

	// top and bottom padding
	assign pad_top = (row_q == '0);
	assign pad_bottom = last_row;

	// ------------------------------------------------
	// window assembly
	// ------------------------------------------------
	always_comb begin
		out_win.layer = layer_q;
		out_win.row = row_q;
		out_win.col = col_q;
		for (int k = 0; k < 3; k++) begin
			for (int j = 0; j < 3; j++) begin
				// zero rows outside the image and bytes past col_count
				if ((k == 0 && pad_top) || (k == 2 && pad_bottom)
						|| (col_q + dim_t'(j) >= cfg.col_count))
					out_win.pix[k][2-j] = '0;
				else
					out_win.pix[k][2-j] = rd_pix[k][2-j];
			end
		end
	end

	// ------------------------------------------------
	// loop counters, column innermost
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			active <= 1'b0;
			rd_bank <= 1'b0;
			col_q <= '0;
			layer_q <= '0;
			row_q <= '0;
			bank_release <= 1'b0;
			run_done <= 1'b0;
		end else if (start) begin
			active <= 1'b1;
			rd_bank <= 1'b0;
			col_q <= '0;
			layer_q <= '0;
			row_q <= '0;
			bank_release <= 1'b0;
			run_done <= 1'b0;
		end else begin
			bank_release <= 1'b0;
			if (out_hs) begin
				if (!last_col) begin
					col_q <= col_q + dim_t'(1);
				end else begin
					// group finished, hand the bank back
					col_q <= '0;
					bank_release <= 1'b1;
					rd_bank <= ~rd_bank;
					if (!last_layer) begin
						layer_q <= layer_q + dim_t'(1);
					end else begin
						layer_q <= '0;
						if (!last_row) begin
							row_q <= row_q + dim_t'(1);
						end else begin
							// stays high until the next start
							active <= 1'b0;
							run_done <= 1'b1;
						end
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- src/layer_reader_top.sv
// -----------------------------------------------
// feature map layer reader
// apb configured, fetches rows over axi read and
// streams 3x3 windows with layer/row/col ids
// -----------------------------------------------
`default_nettype none

`include "layer_reader_cfg.svh"

module layer_reader_top (
	input  logic clk,
	input  logic reset_n,
	// apb slave
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [`LR_ADDR_W-1:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	// axi read address and data
	output logic arvalid,
	input  logic arready,
	output logic [`LR_ADDR_W-1:0] araddr,
	input  logic rvalid,
	output logic rready,
	input  logic [`LR_BEAT_BYTES*8-1:0] rdata,
	input  logic rlast,
	// window stream
	output logic win_valid,
	input  logic win_ready,
	output layer_reader_pkg::window_t win_data
);
	import layer_reader_pkg::*;

	cfg_t cfg;
	logic start;
	logic run_done;
	logic stream_done;
	rd_beat_t r_beat;
	rd_beat_t beat;
	logic beat_valid;
	logic beat_ready;
	logic wr_en;
	logic wr_bank;
	logic [1:0] wr_row;
	logic [$clog2(`LR_BURST_BEATS)-1:0] wr_beat;
	logic [`LR_BEAT_BYTES*8-1:0] wr_data;
	logic [1:0] bank_full;
	logic bank_release;
	logic rd_bank;
	dim_t rd_col;
	win_row_t [0:2] rd_pix;
	logic str_valid;
	logic str_ready;
	window_t str_win;

	assign r_beat = '{data: rdata, last: rlast};
	// run ends once the last window has left the output buffer
	assign run_done = stream_done & ~win_valid;

	apb_cfg_regs u_apb (
		.clk(clk), .reset_n(reset_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.cfg(cfg), .start(start), .run_done(run_done)
	);

	elastic_buffer #(.payload_t(rd_beat_t)) u_rd_buf (
		.clk(clk), .reset_n(reset_n),
		.in_valid(rvalid), .in_ready(rready), .in_data(r_beat),
		.out_valid(beat_valid), .out_ready(beat_ready), .out_data(beat)
	);

	row_fetcher u_fetch (
		.clk(clk), .reset_n(reset_n), .cfg(cfg), .start(start),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.beat_valid(beat_valid), .beat_ready(beat_ready), .beat(beat),
		.wr_en(wr_en), .wr_bank(wr_bank), .wr_row(wr_row), .wr_beat(wr_beat),
		.wr_data(wr_data), .bank_full(bank_full), .bank_release(bank_release)
	);

	line_buffer u_lbuf (
		.clk(clk),
		.wr_en(wr_en), .wr_bank(wr_bank), .wr_row(wr_row), .wr_beat(wr_beat),
		.wr_data(wr_data), .rd_bank(rd_bank), .rd_col(rd_col), .rd_pix(rd_pix)
	);

	window_streamer u_stream (
		.clk(clk), .reset_n(reset_n), .cfg(cfg), .start(start),
		.bank_full(bank_full), .bank_release(bank_release),
		.rd_bank(rd_bank), .rd_col(rd_col), .rd_pix(rd_pix),
		.out_valid(str_valid), .out_ready(str_ready), .out_win(str_win),
		.run_done(stream_done)
	);

	elastic_buffer #(.payload_t(window_t)) u_win_buf (
		.clk(clk), .reset_n(reset_n),
		.in_valid(str_valid), .in_ready(str_ready), .in_data(str_win),
		.out_valid(win_valid), .out_ready(win_ready), .out_data(win_data)
	);

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
// -----------------------------------------------
// testbench clock
// free running, period 8
// -----------------------------------------------
`default_nettype none

module tb_clock_gen (
	output logic clk
);
	localparam int HALF_PERIOD = 4;

	initial clk = 1'b0;

	always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

//--- test/tb_axi_mem.sv
// -----------------------------------------------
// axi read slave memory model
// one burst at a time, data made from the address,
// read data stalls driven from outside
// -----------------------------------------------
`default_nettype none

`include "layer_reader_cfg.svh"

module tb_axi_mem (
	input  logic clk,
	input  logic reset_n,
	input  logic stall,
	input  logic arvalid,
	output logic arready,
	input  logic [`LR_ADDR_W-1:0] araddr,
	output logic rvalid,
	input  logic rready,
	output logic [`LR_BEAT_BYTES*8-1:0] rdata,
	output logic rlast
);
	logic arready_q = 1'b0;
	logic rvalid_q = 1'b0;
	logic [`LR_BEAT_BYTES*8-1:0] rdata_q = '0;
	logic rlast_q = 1'b0;
	logic busy = 1'b0;
	logic [`LR_ADDR_W-1:0] addr_q = '0;
	logic [3:0] beat_q = '0;

	assign arready = arready_q;
	assign rvalid = rvalid_q;
	assign rdata = rdata_q;
	assign rlast = rlast_q;

	// every byte of the address folded into the data
	function automatic logic [7:0] pattern_byte(input logic [31:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
	endfunction

	// byte n of the beat on bits 8n+7:8n
	function automatic logic [63:0] beat_data(input logic [31:0] a);
		logic [63:0] d;
		for (int n = 0; n < `LR_BEAT_BYTES; n++)
			d[n*8 +: 8] = pattern_byte(a + 32'(n));
		return d;
	endfunction

	always @(posedge clk) begin
		if (!reset_n) begin
			arready_q <= 1'b0;
			rvalid_q <= 1'b0;
			rlast_q <= 1'b0;
			busy <= 1'b0;
		end else if (!busy) begin
			// accept one address, then serve its burst
			if (arvalid && arready_q) begin
				addr_q <= araddr;
				beat_q <= '0;
				arready_q <= 1'b0;
				busy <= 1'b1;
			end else begin
				arready_q <= 1'b1;
			end
		end else if (!rvalid_q || rready) begin
			if (rvalid_q && rlast_q) begin
				rvalid_q <= 1'b0;
				rlast_q <= 1'b0;
				busy <= 1'b0;
			end else if (stall) begin
				// gap between beats, never a dropped beat
				rvalid_q <= 1'b0;
			end else begin
				rvalid_q <= 1'b1;
				rdata_q <= beat_data(addr_q + 32'(beat_q) * `LR_BEAT_BYTES);
				rlast_q <= (beat_q == 4'(`LR_BURST_BEATS - 1));
				beat_q <= beat_q + 4'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- test/layer_reader_checker.sv
// -----------------------------------------------
// layer reader protocol checker
// axi address hold and alignment, window hold,
// no window outside a run
// -----------------------------------------------
`default_nettype none

`include "layer_reader_cfg.svh"

module layer_reader_checker (
	input logic clk,
	input logic reset_n,
	input logic arvalid,
	input logic arready,
	input logic [`LR_ADDR_W-1:0] araddr,
	input logic win_valid,
	input logic win_ready,
	input layer_reader_pkg::window_t win_data,
	input logic busy
);
	localparam int ALIGN_W = $clog2(`LR_ROW_BYTES);

	// address channel holds until accepted
	ar_hold: assert property (@(posedge clk) disable iff (!reset_n)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("read address dropped or changed before arready");

	// every burst starts on a row boundary
	ar_align: assert property (@(posedge clk) disable iff (!reset_n)
		arvalid |-> araddr[ALIGN_W-1:0] == '0)
		else $error("read address not 64 byte aligned");

	// window output holds under back-pressure
	win_hold: assert property (@(posedge clk) disable iff (!reset_n)
		win_valid && !win_ready |=> win_valid && $stable(win_data))
		else $error("window dropped or changed while stalled");

	win_in_run: assert property (@(posedge clk) disable iff (!reset_n)
		!busy |-> !win_valid)
		else $error("window valid while not busy");

endmodule

bind layer_reader_top layer_reader_checker u_checker (
	.clk(clk),
	.reset_n(reset_n),
	.arvalid(arvalid),
	.arready(arready),
	.araddr(araddr),
	.win_valid(win_valid),
	.win_ready(win_ready),
	.win_data(win_data),
	.busy(u_apb.busy_q)
);

`default_nettype wire

//--- test/tb_layer_reader.sv
// -----------------------------------------------
// layer reader testbench
// runs a table of configurations over apb and
// checks every window against a golden model
// of the memory pattern
// -----------------------------------------------
`default_nettype none

`include "layer_reader_cfg.svh"

module tb_layer_reader;
	import layer_reader_pkg::*;

	localparam int NUM_RUNS = 4;
	localparam int WIN_TIMEOUT = 4000;
	localparam int APB_TIMEOUT = 16;
	localparam int POLL_LIMIT = 8;

	// one run: stimulus plus the expected window count
	typedef struct packed {
		logic [31:0] base;
		logic [31:0] layers;
		logic [31:0] rows;
		logic [31:0] cols;
		logic stall;
		logic [31:0] windows;
	} run_cfg_t;

	run_cfg_t runs [0:NUM_RUNS-1];

	logic clk;
	logic reset_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`LR_ADDR_W-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic arvalid;
	logic arready;
	logic [`LR_ADDR_W-1:0] araddr;
	logic rvalid;
	logic rready;
	logic [`LR_BEAT_BYTES*8-1:0] rdata;
	logic rlast;
	logic win_valid;
	logic win_ready = 1'b0;
	window_t win_data;
	logic mem_stall = 1'b0;
	logic bp_mode = 1'b0;
	logic [31:0] rnd = 32'he69e;
	int unsigned win_count = 0;

	tb_clock_gen u_clk (.clk(clk));

	layer_reader_top u_dut (
		.clk(clk), .reset_n(reset_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rlast(rlast),
		.win_valid(win_valid), .win_ready(win_ready), .win_data(win_data)
	);

	tb_axi_mem u_mem (
		.clk(clk), .reset_n(reset_n), .stall(mem_stall),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rlast(rlast)
	);

	// ------------------------------------------------
	// helpers
	// ------------------------------------------------
	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [7:0] pattern_byte(input logic [31:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
	endfunction

	// zero outside the image rows and past col_count
	function automatic logic [7:0] expected_pixel(input run_cfg_t rc, input int l,
			input int r, input int c);
		logic [31:0] a;
		if (r < 0 || r >= rc.rows || c >= rc.cols)
			return 8'h00;
		a = rc.base + 32'(l) * `LR_LAYER_BYTES + 32'(r) * `LR_ROW_BYTES + 32'(c);
		return pattern_byte(a);
	endfunction

	// pix[0] is row r-1, earliest column in the top byte
	function automatic window_t expected_window(input run_cfg_t rc, input int l,
			input int r, input int c);
		window_t w;
		w.layer = dim_t'(l);
		w.row = dim_t'(r);
		w.col = dim_t'(c);
		for (int k = 0; k < 3; k++)
			for (int j = 0; j < 3; j++)
				w.pix[k][2-j] = expected_pixel(rc, l, r - 1 + k, c + j);
		return w;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_equal(input string name, input logic [127:0] got,
			input logic [127:0] expected);
		if (got !== expected)
			abort_run($sformatf("FAIL %0t %s: got %0h expected %0h",
				$time, name, got, expected));
	endtask

	// two phase apb transfer, response sampled mid access phase
	task automatic bus_transfer(input logic write, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata_o, output logic err);
		int t;
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		t = 0;
		do begin
			@(negedge clk);
			t++;
			if (t > APB_TIMEOUT)
				abort_run("APB transfer never completed, pready stayed low");
		end while (!pready);
		rdata_o = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] unused_rd;
		logic err;
		bus_transfer(1'b1, addr, data, unused_rd, err);
		check_equal("pslverr on write", err, 1'b0);
	endtask

	task automatic read_reg(input logic [31:0] addr, output logic [31:0] data,
			output logic err);
		bus_transfer(1'b0, addr, 32'h0, data, err);
	endtask

	// the handshake itself happens on the following rising edge
	task automatic wait_window();
		int t;
		t = 0;
		do begin
			@(negedge clk);
			t++;
			if (t > WIN_TIMEOUT)
				abort_run("timeout waiting for an output window");
		end while (!(win_valid && win_ready));
	endtask

	// ------------------------------------------------
	// one table entry
	// ------------------------------------------------
	task automatic run_entry(input run_cfg_t rc);
		logic [31:0] rd;
		logic err;
		int unsigned first_count;
		int polls;
		window_t exp_win;
		bp_mode <= rc.stall;
		write_reg(`LR_REG_BASE, rc.base);
		write_reg(`LR_REG_LAYERS, rc.layers);
		write_reg(`LR_REG_ROWS, rc.rows);
		write_reg(`LR_REG_COLS, rc.cols);
		read_reg(`LR_REG_BASE, rd, err);
		check_equal("BASE readback", rd, rc.base);
		read_reg(`LR_REG_LAYERS, rd, err);
		check_equal("LAYERS readback", rd, rc.layers);
		read_reg(`LR_REG_ROWS, rd, err);
		check_equal("ROWS readback", rd, rc.rows);
		read_reg(`LR_REG_COLS, rd, err);
		check_equal("COLS readback", rd, rc.cols);
		read_reg(32'h0000_0040, rd, err);
		check_equal("pslverr on unmapped read", err, 1'b1);

		first_count = win_count;
		write_reg(`LR_REG_CTRL, 32'h1);
		// row outer, layer middle, column inner
		for (int r = 0; r < rc.rows; r++) begin
			for (int l = 0; l < rc.layers; l++) begin
				for (int c = 0; c < rc.cols; c++) begin
					wait_window();
					exp_win = expected_window(rc, l, r, c);
					check_equal("win_data.row", win_data.row, exp_win.row);
					check_equal("win_data.layer", win_data.layer, exp_win.layer);
					check_equal("win_data.col", win_data.col, exp_win.col);
					check_equal("win_data.pix", win_data.pix, exp_win.pix);
				end
			end
		end

		// done set and busy cleared shortly after the last window
		polls = 0;
		do begin
			read_reg(`LR_REG_STATUS, rd, err);
			polls++;
			if (polls > POLL_LIMIT)
				abort_run("run still busy long after the last window");
		end while (rd[0]);
		check_equal("STATUS done/busy", rd[1:0], 2'b10);
		check_equal("window count", win_count - first_count, rc.windows);
	endtask

	// random back-pressure and read data gaps
	always @(posedge clk) begin
		if (bp_mode) begin
			rnd <= next_random(rnd);
			win_ready <= rnd[3] | rnd[7];
			mem_stall <= rnd[12] & rnd[5];
		end else begin
			win_ready <= 1'b1;
			mem_stall <= 1'b0;
		end
	end

	always @(posedge clk) begin
		if (win_valid && win_ready)
			win_count <= win_count + 1;
	end

	// ------------------------------------------------
	// main sequence
	// ------------------------------------------------
	initial begin
		logic [31:0] rd;
		logic err;
		int unsigned grand_total;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		reset_n = 1'b0;
		grand_total = 0;
		// base, layers, rows, cols, stall, windows
		runs[0] = '{32'h0001_0000, 32'd1, 32'd1, 32'd1, 1'b0, 32'd1};
		runs[1] = '{32'h0002_0000, 32'd2, 32'd3, 32'd5, 1'b0, 32'd30};
		runs[2] = '{32'h0000_0000, 32'd3, 32'd4, 32'd64, 1'b1, 32'd768};
		runs[3] = '{32'h0003_1000, 32'd2, 32'd2, 32'd62, 1'b1, 32'd248};

		repeat (7) @(posedge clk);
		@(negedge clk);
		check_equal("arvalid in reset", arvalid, 1'b0);
		check_equal("rready in reset", rready, 1'b0);
		check_equal("win_valid in reset", win_valid, 1'b0);
		@(posedge clk);
		reset_n <= 1'b1;
		read_reg(`LR_REG_STATUS, rd, err);
		check_equal("STATUS after reset", rd, 32'h0);

		for (int i = 0; i < NUM_RUNS; i++) begin
			run_entry(runs[i]);
			grand_total += runs[i].windows;
		end

		if (win_count != grand_total) begin
			abort_run("total number of windows does not match the table");
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+src
src/layer_reader_pkg.sv
src/elastic_buffer.sv
src/apb_cfg_regs.sv
src/row_fetcher.sv
src/line_buffer.sv
src/window_streamer.sv
src/layer_reader_top.sv
test/tb_clock_gen.sv
test/tb_axi_mem.sv
test/layer_reader_checker.sv
test/tb_layer_reader.sv

//--- run.sh
#!/bin/sh
# compile and run the layer reader testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_layer_reader -f sources.f -o sim_layer_reader

status=0
./obj_dir/sim_layer_reader > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit $status
